//--- src/cuPkg.sv
package cuPkg;

    localparam int InstrWidth = 32;  // instruction word
    localparam int OpcodeHigh = 31;  // opcode field msb
    localparam int OpcodeLow  = 27;  // opcode field lsb

    // instruction opcodes, kept subset only
    typedef enum logic [4:0] {
        OpLd   = 5'b00000,
        OpLdi  = 5'b00001,
        OpSt   = 5'b00010,
        OpAdd  = 5'b00011,
        OpSub  = 5'b00100,
        OpAnd  = 5'b00101,
        OpOr   = 5'b00110,
        OpRor  = 5'b00111,
        OpRol  = 5'b01000,
        OpShr  = 5'b01001,
        OpShra = 5'b01010,
        OpShl  = 5'b01011,
        OpAddi = 5'b01100,
        OpAndi = 5'b01101,
        OpOri  = 5'b01110,
        OpNeg  = 5'b10001,
        OpNot  = 5'b10010,
        OpBr   = 5'b10011,
        OpNop  = 5'b11010,  // new encoding
        OpHalt = 5'b11011   // new encoding
    } opcodeT;

    // execute sequence shape
    typedef enum logic [2:0] {
        ClassAluReg, ClassAluImm, ClassAluUnary, ClassLoad,
        ClassStore, ClassBranch, ClassNop, ClassHalt
    } instrClassT;

    // alu function select, AluNone when alu idle
    typedef enum logic [3:0] {
        AluNone, AluAdd, AluSub, AluAnd, AluOr, AluRor,
        AluRol, AluShr, AluShra, AluShl, AluNeg, AluNot
    } aluOpT;

    typedef enum logic [3:0] {
        StepClear, StepFetch0, StepFetch1, StepFetch2,
        StepExec1, StepExec2, StepExec3, StepExec4, StepExec5,
        StepHalt
    } stepT;

    typedef struct packed {
        logic pcOut;
        logic mdrOut;
        logic zLowOut;
        logic rOut;
        logic cOut;    // sign-extended constant from ir
    } busSourceT;

    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic marIn;
        logic mdrIn;
        logic rIn;
        logic conIn;   // condition flip-flop evaluate
    } loadEnableT;

    // register field select from ir
    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
    } regSelectT;

    typedef struct packed {
        busSourceT  busSource;
        loadEnableT loadEnable;
        regSelectT  regSelect;
        aluOpT      aluOp;
        logic       read;    // memory read into mdr
        logic       write;   // memory write from mdr
        logic       incPc;
        logic       clear;
        logic       halted;
    } controlWordT;         // 25 bits

endpackage

//--- src/opcodeDecoder.sv
module opcodeDecoder (
    input  logic [cuPkg::InstrWidth-1:0] Ir,
    output cuPkg::instrClassT            Class,
    output cuPkg::aluOpT                 AluOp,
    output logic                         Illegal
);

    cuPkg::opcodeT opcode;  // opcode field of ir

    assign opcode = cuPkg::opcodeT'(Ir[cuPkg::OpcodeHigh:cuPkg::OpcodeLow]);

    always_comb begin
        Class   = cuPkg::ClassNop;  // safe default
        AluOp   = cuPkg::AluNone;
        Illegal = 1'b0;
        case (opcode)
            // register-register alu group
            cuPkg::OpAdd: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluAdd;
            end
            cuPkg::OpSub: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluSub;
            end
            cuPkg::OpAnd: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluAnd;
            end
            cuPkg::OpOr: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluOr;
            end
            cuPkg::OpRor: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluRor;
            end
            cuPkg::OpRol: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluRol;
            end
            cuPkg::OpShr: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluShr;
            end
            cuPkg::OpShra: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluShra;  // same flow as shr
            end
            cuPkg::OpShl: begin
                Class = cuPkg::ClassAluReg;
                AluOp = cuPkg::AluShl;
            end
            // immediates reuse add/and/or
            cuPkg::OpAddi: begin
                Class = cuPkg::ClassAluImm;
                AluOp = cuPkg::AluAdd;
            end
            cuPkg::OpAndi: begin
                Class = cuPkg::ClassAluImm;
                AluOp = cuPkg::AluAnd;
            end
            cuPkg::OpOri: begin
                Class = cuPkg::ClassAluImm;
                AluOp = cuPkg::AluOr;
            end
            cuPkg::OpNeg: begin
                Class = cuPkg::ClassAluUnary;
                AluOp = cuPkg::AluNeg;
            end
            cuPkg::OpNot: begin
                Class = cuPkg::ClassAluUnary;
                AluOp = cuPkg::AluNot;
            end
            cuPkg::OpLd, cuPkg::OpLdi: begin
                Class = cuPkg::ClassLoad;    // ld and ldi share the path
                AluOp = cuPkg::AluAdd;       // address = rb + c
            end
            cuPkg::OpSt: begin
                Class = cuPkg::ClassStore;
                AluOp = cuPkg::AluAdd;
            end
            cuPkg::OpBr: begin
                Class = cuPkg::ClassBranch;
                AluOp = cuPkg::AluAdd;       // target = pc + c
            end
            cuPkg::OpNop:  Class = cuPkg::ClassNop;
            cuPkg::OpHalt: Class = cuPkg::ClassHalt;
            default:       Illegal = 1'b1;   // dropped or unassigned opcode
        endcase
    end

endmodule

//--- src/stepSequencer.sv
module stepSequencer (
    input  logic              Clock,
    input  logic              Reset,
    input  cuPkg::instrClassT Class,
    input  cuPkg::aluOpT      AluOp,
    input  logic              Illegal,
    output cuPkg::stepT       Step,
    output cuPkg::instrClassT ExecClass,
    output cuPkg::aluOpT      ExecAluOp
);

    cuPkg::stepT stepNext;      // next step
    cuPkg::stepT lastStep;      // final execute step of latched class
    logic        inExec;        // currently in an execute step

    // final execute step per class
    function automatic cuPkg::stepT lastExecStep(input cuPkg::instrClassT cls);
        case (cls)
            cuPkg::ClassLoad,
            cuPkg::ClassStore,
            cuPkg::ClassBranch: lastExecStep = cuPkg::StepExec5;  // 5 cycles
            cuPkg::ClassNop:    lastExecStep = cuPkg::StepExec1;  // 1 cycle
            default:            lastExecStep = cuPkg::StepExec3;  // alu groups
        endcase
    endfunction

    assign lastStep = lastExecStep(ExecClass);
    assign inExec   = (Step >= cuPkg::StepExec1) && (Step <= cuPkg::StepExec5);

    always_comb begin
        stepNext = cuPkg::StepClear;  // unused codes fall back to clear
        case (Step)
            cuPkg::StepClear:  stepNext = cuPkg::StepFetch0;
            cuPkg::StepFetch0: stepNext = cuPkg::StepFetch1;
            cuPkg::StepFetch1: stepNext = cuPkg::StepFetch2;
            cuPkg::StepFetch2: begin
                if (Illegal)
                    stepNext = cuPkg::StepClear;   // skip execute entirely
                else if (Class == cuPkg::ClassHalt)
                    stepNext = cuPkg::StepHalt;
                else
                    stepNext = cuPkg::StepExec1;
            end
            cuPkg::StepExec1, cuPkg::StepExec2, cuPkg::StepExec3,
            cuPkg::StepExec4, cuPkg::StepExec5: begin
                if (Step == lastStep)
                    stepNext = cuPkg::StepClear;   // sequence done
                else
                    stepNext = cuPkg::stepT'(Step + 4'd1);
            end
            cuPkg::StepHalt:   stepNext = cuPkg::StepHalt;  // only Reset leaves
            default:           stepNext = cuPkg::StepClear;
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            Step      <= cuPkg::StepClear;
            ExecClass <= cuPkg::ClassNop;
            ExecAluOp <= cuPkg::AluNone;
        end else begin
            Step <= stepNext;
            if (Step == cuPkg::StepFetch2) begin
                ExecClass <= Class;   // ir decoded during last fetch step
                ExecAluOp <= AluOp;
            end
        end
    end

    // an execute step never passes the final step of the latched class
    execWithinLength: assert property (@(posedge Clock) disable iff (Reset)
        inExec |-> Step <= lastStep)
        else $error("execute sequence ran past its class length");

    haltHolds: assert property (@(posedge Clock) disable iff (Reset)
        Step == cuPkg::StepHalt |=> Step == cuPkg::StepHalt)
        else $error("sequencer left halt without reset");

endmodule

//--- src/controlEncoder.sv
module controlEncoder (
    input  cuPkg::stepT        Step,
    input  cuPkg::instrClassT  ExecClass,
    input  cuPkg::aluOpT       ExecAluOp,
    input  logic               ConFf,
    output cuPkg::controlWordT Control
);

    always_comb begin
        Control       = '0;               // everything idle unless set below
        Control.aluOp = cuPkg::AluNone;
        case (Step)
            cuPkg::StepClear: begin
                Control.loadEnable.pcIn = 1'b1;   // pc loads zero
                Control.clear           = 1'b1;
            end
            cuPkg::StepFetch0: begin
                Control.busSource.pcOut  = 1'b1;
                Control.loadEnable.marIn = 1'b1;  // mar = pc
                Control.incPc            = 1'b1;
            end
            cuPkg::StepFetch1: begin
                Control.read             = 1'b1;
                Control.loadEnable.mdrIn = 1'b1;  // instruction into mdr
            end
            cuPkg::StepFetch2: begin
                Control.busSource.mdrOut = 1'b1;
                Control.loadEnable.irIn  = 1'b1;
            end
            cuPkg::StepExec1, cuPkg::StepExec2, cuPkg::StepExec3,
            cuPkg::StepExec4, cuPkg::StepExec5: begin
                case (ExecClass)
                    cuPkg::ClassAluReg, cuPkg::ClassAluImm, cuPkg::ClassAluUnary: begin
                        case (Step)
                            cuPkg::StepExec1: begin
                                Control.regSelect.grb  = 1'b1;  // y = rb
                                Control.busSource.rOut = 1'b1;
                                Control.loadEnable.yIn = 1'b1;
                            end
                            cuPkg::StepExec2: begin
                                Control.loadEnable.zIn = 1'b1;
                                Control.aluOp          = ExecAluOp;
                                if (ExecClass == cuPkg::ClassAluReg) begin
                                    Control.regSelect.grc  = 1'b1;  // second operand rc
                                    Control.busSource.rOut = 1'b1;
                                end else if (ExecClass == cuPkg::ClassAluImm) begin
                                    Control.busSource.cOut = 1'b1;  // immediate operand
                                end
                                // unary ops work on y alone, bus stays idle
                            end
                            cuPkg::StepExec3: begin
                                Control.busSource.zLowOut = 1'b1;  // ra = result
                                Control.regSelect.gra     = 1'b1;
                                Control.loadEnable.rIn    = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    cuPkg::ClassLoad, cuPkg::ClassStore: begin
                        case (Step)
                            cuPkg::StepExec1: begin
                                Control.regSelect.grb  = 1'b1;  // base register
                                Control.busSource.rOut = 1'b1;
                                Control.loadEnable.yIn = 1'b1;
                            end
                            cuPkg::StepExec2: begin
                                Control.busSource.cOut = 1'b1;  // offset
                                Control.loadEnable.zIn = 1'b1;
                                Control.aluOp          = cuPkg::AluAdd;
                            end
                            cuPkg::StepExec3: begin
                                Control.busSource.zLowOut = 1'b1;  // effective address
                                Control.loadEnable.marIn  = 1'b1;
                            end
                            cuPkg::StepExec4: begin
                                Control.loadEnable.mdrIn = 1'b1;
                                if (ExecClass == cuPkg::ClassLoad) begin
                                    Control.read = 1'b1;           // mdr from memory
                                end else begin
                                    Control.regSelect.gra  = 1'b1;  // mdr from ra
                                    Control.busSource.rOut = 1'b1;
                                end
                            end
                            cuPkg::StepExec5: begin
                                if (ExecClass == cuPkg::ClassLoad) begin
                                    Control.busSource.mdrOut = 1'b1;  // writeback to ra
                                    Control.regSelect.gra    = 1'b1;
                                    Control.loadEnable.rIn   = 1'b1;
                                end else begin
                                    Control.write = 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                    cuPkg::ClassBranch: begin
                        case (Step)
                            cuPkg::StepExec1: begin
                                Control.regSelect.gra    = 1'b1;  // test ra
                                Control.busSource.rOut   = 1'b1;
                                Control.loadEnable.conIn = 1'b1;
                            end
                            cuPkg::StepExec2: begin
                                Control.busSource.pcOut = 1'b1;
                                Control.loadEnable.yIn  = 1'b1;
                            end
                            cuPkg::StepExec3: begin
                                Control.busSource.cOut = 1'b1;  // displacement
                                Control.loadEnable.zIn = 1'b1;
                                Control.aluOp          = cuPkg::AluAdd;
                            end
                            cuPkg::StepExec4: begin
                                if (ConFf)
                                    Control.busSource.zLowOut = 1'b1;  // taken
                                else
                                    Control.incPc = 1'b1;              // fall through
                            end
                            cuPkg::StepExec5: Control.loadEnable.pcIn = ConFf;
                            default: ;
                        endcase
                    end
                    default: ;  // nop step stays all zero
                endcase
            end
            cuPkg::StepHalt: Control.halted = 1'b1;
            default: ;
        endcase
    end

    // single bus, so the datapath tolerates at most one driver
    always_comb begin
        busSingleDriver: assert ($onehot0(Control.busSource))
            else $error("more than one bus source active");
        memNoReadWrite: assert (!(Control.read && Control.write))
            else $error("memory read and write in the same step");
    end

endmodule

//--- src/controlUnit.sv
module controlUnit (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [cuPkg::InstrWidth-1:0] Ir,
    input  logic                         ConFf,
    output cuPkg::controlWordT           Control
);

    cuPkg::instrClassT instrClass;   // decoded, live during fetch2
    cuPkg::aluOpT      aluOp;
    logic              illegal;
    cuPkg::stepT       step;
    cuPkg::instrClassT execClass;    // latched at end of fetch2
    cuPkg::aluOpT      execAluOp;

    opcodeDecoder opcodeDecoder_i (
        .Ir      (Ir),
        .Class   (instrClass),
        .AluOp   (aluOp),
        .Illegal (illegal)
    );

    stepSequencer stepSequencer_i (
        .Clock     (Clock),
        .Reset     (Reset),
        .Class     (instrClass),
        .AluOp     (aluOp),
        .Illegal   (illegal),
        .Step      (step),
        .ExecClass (execClass),
        .ExecAluOp (execAluOp)
    );

    // control word is combinational from step state and ConFf
    controlEncoder controlEncoder_i (
        .Step      (step),
        .ExecClass (execClass),
        .ExecAluOp (execAluOp),
        .ConFf     (ConFf),
        .Control   (Control)
    );

endmodule

//--- include/cuModel.svh
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

cuPkg::stepT       refStep;       // predicted step
cuPkg::instrClassT refClass;      // class latched at fetch2
cuPkg::aluOpT      refAluOp;
int                refExecCount;  // execute steps done so far

localparam cuPkg::stepT ExecSteps [5] = '{cuPkg::StepExec1, cuPkg::StepExec2,
    cuPkg::StepExec3, cuPkg::StepExec4, cuPkg::StepExec5};

// bit columns follow the struct
// bus: pcOut mdrOut zLowOut rOut cOut
// load: pcIn irIn yIn zIn marIn mdrIn rIn conIn
// sel: gra grb grc, misc: read write incPc clear halted
function automatic cuPkg::controlWordT wordOf(input logic [4:0] bus, input logic [7:0] load,
        input logic [2:0] sel, input cuPkg::aluOpT op, input logic [4:0] misc);
    return cuPkg::controlWordT'({bus, load, sel, op, misc});
endfunction

function automatic int execLength(input cuPkg::instrClassT cls);
    case (cls)
        cuPkg::ClassLoad, cuPkg::ClassStore, cuPkg::ClassBranch: return 5;
        cuPkg::ClassNop: return 1;
        default: return 3;  // all alu classes
    endcase
endfunction

// returns 1 for a kept opcode
function automatic logic decodeOpcode(input logic [4:0] opc,
        output cuPkg::instrClassT cls, output cuPkg::aluOpT op);
    logic legal;
    legal = 1'b1;
    cls   = cuPkg::ClassNop;
    op    = cuPkg::AluNone;
    if (opc >= cuPkg::OpAdd && opc <= cuPkg::OpShl) begin
        cls = cuPkg::ClassAluReg;
        op  = cuPkg::aluOpT'(4'(opc - 5'd2));  // alu list runs in opcode order from add
    end else begin
        case (opc)
            cuPkg::OpAddi, cuPkg::OpAndi, cuPkg::OpOri: begin
                cls = cuPkg::ClassAluImm;
                op  = (opc == cuPkg::OpAddi) ? cuPkg::AluAdd :
                      (opc == cuPkg::OpAndi) ? cuPkg::AluAnd : cuPkg::AluOr;
            end
            cuPkg::OpNeg, cuPkg::OpNot: begin
                cls = cuPkg::ClassAluUnary;
                op  = (opc == cuPkg::OpNeg) ? cuPkg::AluNeg : cuPkg::AluNot;
            end
            cuPkg::OpLd, cuPkg::OpLdi: cls = cuPkg::ClassLoad;
            cuPkg::OpSt:   cls = cuPkg::ClassStore;
            cuPkg::OpBr:   cls = cuPkg::ClassBranch;
            cuPkg::OpNop:  cls = cuPkg::ClassNop;
            cuPkg::OpHalt: cls = cuPkg::ClassHalt;
            default:       legal = 1'b0;  // dropped or unassigned
        endcase
    end
    return legal;
endfunction

task automatic restartSequence();
    refStep      = cuPkg::StepClear;
    refClass     = cuPkg::ClassNop;
    refAluOp     = cuPkg::AluNone;
    refExecCount = 0;
endtask

function automatic cuPkg::controlWordT predictControl(input cuPkg::stepT step,
        input cuPkg::instrClassT cls, input cuPkg::aluOpT op, input logic conFf);
    cuPkg::controlWordT w;
    int                 n;
    w = '0;
    n = int'(step) - int'(cuPkg::StepExec1) + 1;  // execute index 1..5
    case (step)
        cuPkg::StepClear:  w = wordOf(5'b00000, 8'b10000000, 3'b000, cuPkg::AluNone, 5'b00010);
        cuPkg::StepFetch0: w = wordOf(5'b10000, 8'b00001000, 3'b000, cuPkg::AluNone, 5'b00100);
        cuPkg::StepFetch1: w = wordOf(5'b00000, 8'b00000100, 3'b000, cuPkg::AluNone, 5'b10000);
        cuPkg::StepFetch2: w = wordOf(5'b01000, 8'b01000000, 3'b000, cuPkg::AluNone, 5'b00000);
        cuPkg::StepHalt:   w = wordOf(5'b00000, 8'b00000000, 3'b000, cuPkg::AluNone, 5'b00001);
        default: begin
            case (cls)
                cuPkg::ClassAluReg, cuPkg::ClassAluImm, cuPkg::ClassAluUnary: begin
                    case (n)
                        1: w = wordOf(5'b00010, 8'b00100000, 3'b010, cuPkg::AluNone, 5'b0);
                        2: begin
                            if (cls == cuPkg::ClassAluReg)
                                w = wordOf(5'b00010, 8'b00010000, 3'b001, op, 5'b0);
                            else if (cls == cuPkg::ClassAluImm)
                                w = wordOf(5'b00001, 8'b00010000, 3'b000, op, 5'b0);
                            else
                                w = wordOf(5'b00000, 8'b00010000, 3'b000, op, 5'b0);
                        end
                        3: w = wordOf(5'b00100, 8'b00000010, 3'b100, cuPkg::AluNone, 5'b0);
                        default: ;
                    endcase
                end
                cuPkg::ClassLoad, cuPkg::ClassStore: begin
                    case (n)
                        1: w = wordOf(5'b00010, 8'b00100000, 3'b010, cuPkg::AluNone, 5'b0);
                        2: w = wordOf(5'b00001, 8'b00010000, 3'b000, cuPkg::AluAdd, 5'b0);
                        3: w = wordOf(5'b00100, 8'b00001000, 3'b000, cuPkg::AluNone, 5'b0);
                        4: w = (cls == cuPkg::ClassLoad)
                            ? wordOf(5'b00000, 8'b00000100, 3'b000, cuPkg::AluNone, 5'b10000)
                            : wordOf(5'b00010, 8'b00000100, 3'b100, cuPkg::AluNone, 5'b0);
                        5: w = (cls == cuPkg::ClassLoad)
                            ? wordOf(5'b01000, 8'b00000010, 3'b100, cuPkg::AluNone, 5'b0)
                            : wordOf(5'b00000, 8'b00000000, 3'b000, cuPkg::AluNone, 5'b01000);
                        default: ;
                    endcase
                end
                cuPkg::ClassBranch: begin
                    case (n)
                        1: w = wordOf(5'b00010, 8'b00000001, 3'b100, cuPkg::AluNone, 5'b0);
                        2: w = wordOf(5'b10000, 8'b00100000, 3'b000, cuPkg::AluNone, 5'b0);
                        3: w = wordOf(5'b00001, 8'b00010000, 3'b000, cuPkg::AluAdd, 5'b0);
                        4: w = wordOf({2'b00, conFf, 2'b00}, 8'b0, 3'b000, cuPkg::AluNone,
                                      {2'b00, ~conFf, 2'b00});  // taken or fall through
                        5: w = wordOf(5'b0, {conFf, 7'b0}, 3'b000, cuPkg::AluNone, 5'b0);
                        default: ;
                    endcase
                end
                default: ;  // nop step all zero
            endcase
        end
    endcase
    return w;
endfunction

// one clock edge of the sequencer, from values seen before the edge
task automatic advanceStep(input logic [cuPkg::InstrWidth-1:0] ir, input logic rst);
    cuPkg::instrClassT cls;
    cuPkg::aluOpT      op;
    logic              legal;
    legal = decodeOpcode(ir[cuPkg::OpcodeHigh:cuPkg::OpcodeLow], cls, op);
    if (rst) begin
        restartSequence();
    end else begin
        case (refStep)
            cuPkg::StepClear:  refStep = cuPkg::StepFetch0;
            cuPkg::StepFetch0: refStep = cuPkg::StepFetch1;
            cuPkg::StepFetch1: refStep = cuPkg::StepFetch2;
            cuPkg::StepFetch2: begin
                refClass     = cls;
                refAluOp     = op;
                refExecCount = 1;
                if (!legal)
                    refStep = cuPkg::StepClear;
                else if (cls == cuPkg::ClassHalt)
                    refStep = cuPkg::StepHalt;
                else
                    refStep = ExecSteps[0];
            end
            cuPkg::StepHalt: ;  // parked
            default: begin
                if (refExecCount >= execLength(refClass)) begin
                    refStep = cuPkg::StepClear;
                end else begin
                    refExecCount++;
                    refStep = ExecSteps[refExecCount - 1];
                end
            end
        endcase
    end
endtask

`endif

//--- testbench/tbControlUnit.sv
module tbControlUnit;

    localparam int     ClockPeriod    = 100;
    localparam int     InstrTotal     = 400;
    localparam int     MaxInstrCycles = 9;   // fetch plus longest execute
    localparam int     HaltHold       = 20;  // cycles parked before reset
    localparam longint WatchdogTime   = (InstrTotal * MaxInstrCycles + 1000) * ClockPeriod;

    logic                         Clock;
    logic                         Reset;
    logic [cuPkg::InstrWidth-1:0] Ir;
    logic                         ConFf;
    cuPkg::controlWordT           Control;

    integer                       seed;
    int                           instrCount;
    int                           haltCycles;
    logic [cuPkg::InstrWidth-1:0] nextIr;

    `include "cuModel.svh"

    controlUnit dut_i (
        .Clock   (Clock),
        .Reset   (Reset),
        .Ir      (Ir),
        .ConFf   (ConFf),
        .Control (Control)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    task automatic stopOnFailure(input string reason);
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic compareAluOp(input cuPkg::aluOpT got, input cuPkg::aluOpT exp);
        if (got !== exp) begin
            $display("FAIL %0t: aluOp is %s, expected %s in step %s",
                     $time, got.name(), exp.name(), refStep.name());
            stopOnFailure("alu operation mismatch");
        end
    endtask

    task automatic compareControlWord(input cuPkg::controlWordT got,
                                      input cuPkg::controlWordT exp);
        string field;
        if (got !== exp) begin
            if (got.busSource !== exp.busSource) field = "busSource";
            else if (got.loadEnable !== exp.loadEnable) field = "loadEnable";
            else if (got.regSelect !== exp.regSelect) field = "regSelect";
            else field = "read/write/incPc/clear/halted";
            $display("FAIL %0t: %s wrong in step %s, word %b expected %b",
                     $time, field, refStep.name(), got, exp);
            stopOnFailure("control word mismatch");
        end
    endtask

    // mostly kept opcodes with some illegal ones and a rare halt
    task automatic drawInstruction(output logic [cuPkg::InstrWidth-1:0] ir);
        int                roll;
        logic [31:0]       rnd;
        logic [4:0]        opc;
        cuPkg::instrClassT cls;
        cuPkg::aluOpT      op;
        roll = {$random(seed)} % 100;
        ir   = $random(seed);  // register and constant fields
        if (roll < 2) begin
            opc = cuPkg::OpHalt;
        end else if (roll < 14) begin
            do begin
                rnd = $random(seed);
                opc = rnd[4:0];
            end while (decodeOpcode(opc, cls, op));  // redraw until illegal
        end else begin
            do begin
                rnd = $random(seed);
                opc = rnd[4:0];
            end while (!decodeOpcode(opc, cls, op) || opc == cuPkg::OpHalt);
        end
        ir[cuPkg::OpcodeHigh:cuPkg::OpcodeLow] = opc;
    endtask

    // control settles by mid-cycle since it is combinational from the step
    initial begin
        cuPkg::controlWordT expected;
        @(posedge Clock);  // skip the time zero clock edge
        forever begin
            @(negedge Clock);
            expected = predictControl(refStep, refClass, refAluOp, ConFf);
            compareAluOp(Control.aluOp, expected.aluOp);
            compareControlWord(Control, expected);
        end
    end

    initial begin
        logic [31:0] rnd;
        seed       = 71;
        Reset      = 1'b1;
        Ir         = '0;
        ConFf      = 1'b0;
        nextIr     = '0;
        instrCount = 0;
        haltCycles = 0;
        restartSequence();
        repeat (8) @(posedge Clock);
        Reset <= 1'b0;
        while (instrCount < InstrTotal || refStep != cuPkg::StepClear) begin
            @(posedge Clock);
            if (refStep == cuPkg::StepClear && !Reset) begin
                drawInstruction(nextIr);  // held through fetch2
                Ir <= nextIr;
                instrCount++;
            end
            advanceStep(Ir, Reset);
            rnd = $random(seed);
            ConFf <= rnd[0];
            if (Reset) begin
                Reset <= 1'b0;  // single reset cycle after halt
            end else if (refStep == cuPkg::StepHalt) begin
                haltCycles++;
                if (haltCycles == HaltHold) begin
                    Reset <= 1'b1;
                    haltCycles = 0;
                    restartSequence();  // async reset clears right after this edge
                end
            end
        end
        @(negedge Clock);
        @(posedge Clock);
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(WatchdogTime);
        $display("watchdog expired before all %0d instructions completed", InstrTotal);
        stopOnFailure("simulation timed out");
    end

endmodule

//--- files.f
+incdir+include
src/cuPkg.sv
src/opcodeDecoder.sv
src/stepSequencer.sv
src/controlEncoder.sv
src/controlUnit.sv
testbench/tbControlUnit.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tbControlUnit -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
